// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// rename group shape
`define RENAME_WIDTH 2
`define NUMSRCS_INT 2

// data path width
`define XLEN 32

// integer register counts
`define ARCH_REGS 32
`define PRF_SIZE 48

// register file port counts
`define PRF_READPORTS 4
`define PRF_WBPORTS 2

// bit-range helpers
`define WDEF(n) ((n)-1):0
`define XDEF (`XLEN-1):0

`endif

// File: src/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    // one data word
    typedef logic [`XDEF] word_t;

    // physical register number
    typedef logic [$clog2(`PRF_SIZE)-1:0] iprIdx_t;

    // architectural register number
    typedef logic [$clog2(`ARCH_REGS)-1:0] ilrIdx_t;

    // free list fills itself after reset, then runs
    typedef enum logic {
        FL_INIT,
        FL_RUN
    } fl_state_e;

endpackage

// File: src/prf_status_if.sv
`timescale 1ns/1ps
`include "core_settings.svh"

interface prf_status_if;
    import core_pkg::*;

    // new destinations from rename become not ready
    logic [`WDEF(`RENAME_WIDTH)] notready_mark;
    iprIdx_t notready_iprIdx [`RENAME_WIDTH];

    // source readiness query and answer for dispatch
    iprIdx_t check_iprsIdx [`RENAME_WIDTH][`NUMSRCS_INT];
    logic [`WDEF(`NUMSRCS_INT)] check_vld [`RENAME_WIDTH];

    modport disp (
        output notready_mark,
        output notready_iprIdx,
        output check_iprsIdx,
        input check_vld
    );

    modport prf (
        input notready_mark,
        input notready_iprIdx,
        input check_iprsIdx,
        output check_vld
    );
endinterface

// File: src/regfile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module regfile #(
    parameter int READPORT_NUM = 4,
    parameter int WBPORT_NUM = 2,
    parameter int SIZE = 48
) (
    input logic clk,
    input logic rst,

    // combinational read ports
    input core_pkg::iprIdx_t i_read_idx [READPORT_NUM],
    output core_pkg::word_t o_read_data [READPORT_NUM],
    output logic [`WDEF(READPORT_NUM)] o_data_rdy,

    // writeback ports
    input logic [`WDEF(WBPORT_NUM)] i_write_en,
    input core_pkg::iprIdx_t i_write_idx [WBPORT_NUM],
    input core_pkg::word_t i_write_data [WBPORT_NUM],

    prf_status_if.prf status
);
    import core_pkg::*;

    // register 0 is not stored
    word_t buffer [1:SIZE-1];
    logic [SIZE-1:1] rdy_bit;
    logic [SIZE-1:1] rdy_bypass;

    // writebacks override same-cycle marks
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_bit <= '1;
        end else begin
            for (int m = 0; m < `RENAME_WIDTH; m++) begin
                if (status.notready_mark[m] && status.notready_iprIdx[m] != '0) begin
                    rdy_bit[status.notready_iprIdx[m]] <= 1'b0;
                end
            end
            for (int p = 0; p < WBPORT_NUM; p++) begin
                if (i_write_en[p] && i_write_idx[p] != '0) begin
                    rdy_bit[i_write_idx[p]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < WBPORT_NUM; p++) begin
            if (i_write_en[p] && i_write_idx[p] != '0) begin
                buffer[i_write_idx[p]] <= i_write_data[p];
            end
        end
    end

    // same-cycle writeback shows as ready
    always_comb begin
        rdy_bypass = rdy_bit;
        for (int p = 0; p < WBPORT_NUM; p++) begin
            if (i_write_en[p] && i_write_idx[p] != '0) begin
                rdy_bypass[i_write_idx[p]] = 1'b1;
            end
        end
    end

    for (genvar r = 0; r < READPORT_NUM; r++) begin : gen_read
        assign o_read_data[r] = (i_read_idx[r] == '0) ? '0 : buffer[i_read_idx[r]];
        assign o_data_rdy[r] = (i_read_idx[r] == '0) ? 1'b1 : rdy_bypass[i_read_idx[r]];
    end

    // one dispatch readiness answer per source
    for (genvar s = 0; s < `RENAME_WIDTH; s++) begin : gen_chk_slot
        for (genvar k = 0; k < `NUMSRCS_INT; k++) begin : gen_chk_src
            assign status.check_vld[s][k] = (status.check_iprsIdx[s][k] == '0) ?
                1'b1 : rdy_bypass[status.check_iprsIdx[s][k]];
        end
    end

    // two ports hitting one register would leave the data undefined
    for (genvar p = 0; p < WBPORT_NUM; p++) begin : gen_wb_chk
        for (genvar q = p + 1; q < WBPORT_NUM; q++) begin : gen_wb_pair
            a_wb_distinct: assert property (
                @(posedge clk) disable iff (rst)
                !(i_write_en[p] && i_write_en[q] && i_write_idx[p] == i_write_idx[q])
            ) else $error("writeback ports %0d and %0d share an index", p, q);
        end
    end

endmodule

// File: src/free_list.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module free_list (
    input logic clk,
    input logic rst,

    // allocation towards rename
    input logic [`WDEF(`RENAME_WIDTH)] i_alloc_take,
    output core_pkg::iprIdx_t o_alloc_idx [`RENAME_WIDTH],
    output logic o_can_alloc,

    // registers returned by commit
    input logic i_free_vld,
    input core_pkg::iprIdx_t i_free_idx
);
    import core_pkg::*;

    localparam int DEPTH = `PRF_SIZE - `ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    fl_state_e state;
    iprIdx_t queue [DEPTH];
    ptr_t head;
    ptr_t tail;
    cnt_t count;
    iprIdx_t init_idx;
    cnt_t pop_num;
    logic push_en;
    logic wr_en;
    iprIdx_t wr_idx;

    function automatic ptr_t ptr_add(ptr_t p, int unsigned n);
        int unsigned sum;
        sum = int'(p) + n;
        return ptr_t'(sum % DEPTH);
    endfunction

    // each slot sees the entry after those taken by earlier slots
    always_comb begin
        pop_num = '0;
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            o_alloc_idx[s] = queue[ptr_add(head, pop_num)];
            pop_num = pop_num + cnt_t'(i_alloc_take[s]);
        end
    end

    assign push_en = (state == FL_RUN) && i_free_vld && (i_free_idx != '0);
    assign wr_en = (state == FL_INIT) || push_en;
    assign wr_idx = (state == FL_INIT) ? init_idx : i_free_idx;
    assign o_can_alloc = (state == FL_RUN) && (count >= cnt_t'(`RENAME_WIDTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FL_INIT;
            init_idx <= iprIdx_t'(`ARCH_REGS);
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (state == FL_INIT) begin
            // load ARCH_REGS .. PRF_SIZE-1 in order
            tail <= ptr_add(tail, 1);
            count <= count + 1'b1;
            init_idx <= init_idx + 1'b1;
            if (init_idx == iprIdx_t'(`PRF_SIZE - 1)) begin
                state <= FL_RUN;
            end
        end else begin
            head <= ptr_add(head, pop_num);
            if (push_en) begin
                tail <= ptr_add(tail, 1);
            end
            count <= count - pop_num + cnt_t'(push_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            queue[tail] <= wr_idx;
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) (|i_alloc_take) |-> o_can_alloc
    ) else $error("free list popped without enough entries");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push_en |-> (count != cnt_t'(DEPTH))
    ) else $error("free list pushed while full");

endmodule

// File: src/rename_map.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module rename_map (
    input logic clk,
    input logic rst,

    // rename group
    input logic i_rename_vld,
    input core_pkg::ilrIdx_t i_rename_rd [`RENAME_WIDTH],
    input core_pkg::ilrIdx_t i_rename_rs [`RENAME_WIDTH][`NUMSRCS_INT],
    output logic o_rename_ready,

    // free list
    input core_pkg::iprIdx_t i_alloc_idx [`RENAME_WIDTH],
    input logic i_can_alloc,
    output logic [`WDEF(`RENAME_WIDTH)] o_alloc_take,

    // dispatch stage
    output logic o_disp_vld,
    output core_pkg::iprIdx_t o_disp_iprd [`RENAME_WIDTH],
    output core_pkg::iprIdx_t o_disp_old_iprd [`RENAME_WIDTH],
    output core_pkg::iprIdx_t o_disp_iprs [`RENAME_WIDTH][`NUMSRCS_INT],
    output logic [`WDEF(`NUMSRCS_INT)] o_disp_rdy [`RENAME_WIDTH],

    prf_status_if.disp status
);
    import core_pkg::*;

    // entry 0 is fixed to physical register 0
    iprIdx_t map_table [1:`ARCH_REGS-1];
    logic accept;
    iprIdx_t new_iprd [`RENAME_WIDTH];
    iprIdx_t ren_old_iprd [`RENAME_WIDTH];
    iprIdx_t ren_iprs [`RENAME_WIDTH][`NUMSRCS_INT];

    function automatic iprIdx_t map_lookup(ilrIdx_t a);
        return (a == '0) ? '0 : map_table[a];
    endfunction

    assign o_rename_ready = i_can_alloc;
    assign accept = i_rename_vld && o_rename_ready;

    for (genvar s = 0; s < `RENAME_WIDTH; s++) begin : gen_take
        assign o_alloc_take[s] = accept && (i_rename_rd[s] != '0);
    end

    // table lookup, then forwarding from earlier slots of the group
    always_comb begin
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            new_iprd[s] = (i_rename_rd[s] != '0) ? i_alloc_idx[s] : '0;
            ren_old_iprd[s] = map_lookup(i_rename_rd[s]);
            for (int k = 0; k < `NUMSRCS_INT; k++) begin
                ren_iprs[s][k] = map_lookup(i_rename_rs[s][k]);
            end
            for (int p = 0; p < s; p++) begin
                if (i_rename_rd[p] != '0) begin
                    if (i_rename_rd[p] == i_rename_rd[s]) begin
                        ren_old_iprd[s] = new_iprd[p];
                    end
                    for (int k = 0; k < `NUMSRCS_INT; k++) begin
                        if (i_rename_rd[p] == i_rename_rs[s][k]) begin
                            ren_iprs[s][k] = new_iprd[p];
                        end
                    end
                end
            end
        end
    end

    // later slot wins on a shared destination
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 1; a < `ARCH_REGS; a++) begin
                map_table[a] <= iprIdx_t'(a);
            end
        end else begin
            for (int s = 0; s < `RENAME_WIDTH; s++) begin
                if (o_alloc_take[s]) begin
                    map_table[i_rename_rd[s]] <= i_alloc_idx[s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_disp_vld <= 1'b0;
        end else begin
            o_disp_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_disp_iprd <= new_iprd;
            o_disp_old_iprd <= ren_old_iprd;
            o_disp_iprs <= ren_iprs;
        end
    end

    // new destinations are marked at acceptance, queried from dispatch
    assign status.notready_mark = o_alloc_take;
    assign status.notready_iprIdx = i_alloc_idx;
    assign status.check_iprsIdx = o_disp_iprs;
    assign o_disp_rdy = status.check_vld;

    // an accepted slot must get a real register from the free list
    for (genvar s = 0; s < `RENAME_WIDTH; s++) begin : gen_take_chk
        a_take_has_reg: assert property (
            @(posedge clk) disable iff (rst) o_alloc_take[s] |-> (i_alloc_idx[s] != '0)
        ) else $error("slot %0d accepted without a free register", s);
    end

endmodule

// File: src/int_rename_prf.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module int_rename_prf (
    input logic clk,
    input logic rst,

    // rename
    input logic i_rename_vld,
    input core_pkg::ilrIdx_t i_rename_rd [`RENAME_WIDTH],
    input core_pkg::ilrIdx_t i_rename_rs [`RENAME_WIDTH][`NUMSRCS_INT],
    output logic o_rename_ready,

    // dispatch
    output logic o_disp_vld,
    output core_pkg::iprIdx_t o_disp_iprd [`RENAME_WIDTH],
    output core_pkg::iprIdx_t o_disp_old_iprd [`RENAME_WIDTH],
    output core_pkg::iprIdx_t o_disp_iprs [`RENAME_WIDTH][`NUMSRCS_INT],
    output logic [`WDEF(`NUMSRCS_INT)] o_disp_rdy [`RENAME_WIDTH],

    // writeback
    input logic [`WDEF(`PRF_WBPORTS)] i_wb_en,
    input core_pkg::iprIdx_t i_wb_idx [`PRF_WBPORTS],
    input core_pkg::word_t i_wb_data [`PRF_WBPORTS],

    // operand reads
    input core_pkg::iprIdx_t i_read_idx [`PRF_READPORTS],
    output core_pkg::word_t o_read_data [`PRF_READPORTS],
    output logic [`WDEF(`PRF_READPORTS)] o_data_rdy,

    // commit
    input logic i_commit_vld,
    input core_pkg::iprIdx_t i_commit_iprIdx
);
    import core_pkg::*;

    iprIdx_t alloc_idx [`RENAME_WIDTH];
    logic can_alloc;
    logic [`WDEF(`RENAME_WIDTH)] alloc_take;

    prf_status_if u_status ();

    rename_map u_rename_map (
        .clk(clk),
        .rst(rst),
        .i_rename_vld(i_rename_vld),
        .i_rename_rd(i_rename_rd),
        .i_rename_rs(i_rename_rs),
        .o_rename_ready(o_rename_ready),
        .i_alloc_idx(alloc_idx),
        .i_can_alloc(can_alloc),
        .o_alloc_take(alloc_take),
        .o_disp_vld(o_disp_vld),
        .o_disp_iprd(o_disp_iprd),
        .o_disp_old_iprd(o_disp_old_iprd),
        .o_disp_iprs(o_disp_iprs),
        .o_disp_rdy(o_disp_rdy),
        .status(u_status.disp)
    );

    free_list u_free_list (
        .clk(clk),
        .rst(rst),
        .i_alloc_take(alloc_take),
        .o_alloc_idx(alloc_idx),
        .o_can_alloc(can_alloc),
        .i_free_vld(i_commit_vld),
        .i_free_idx(i_commit_iprIdx)
    );

    regfile #(
        .READPORT_NUM(`PRF_READPORTS),
        .WBPORT_NUM(`PRF_WBPORTS),
        .SIZE(`PRF_SIZE)
    ) u_regfile (
        .clk(clk),
        .rst(rst),
        .i_read_idx(i_read_idx),
        .o_read_data(o_read_data),
        .o_data_rdy(o_data_rdy),
        .i_write_en(i_wb_en),
        .i_write_idx(i_wb_idx),
        .i_write_data(i_wb_data),
        .status(u_status.prf)
    );

endmodule

// File: verification/tb_int_rename_prf.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_int_rename_prf;
    import core_pkg::*;

    localparam int RW = `RENAME_WIDTH;
    localparam int NS = `NUMSRCS_INT;
    localparam int WAIT_LIMIT = 64;

    logic clk;
    logic rst;
    logic i_rename_vld;
    ilrIdx_t i_rename_rd [RW];
    ilrIdx_t i_rename_rs [RW][NS];
    logic o_rename_ready;
    logic o_disp_vld;
    iprIdx_t o_disp_iprd [RW];
    iprIdx_t o_disp_old_iprd [RW];
    iprIdx_t o_disp_iprs [RW][NS];
    logic [`WDEF(`NUMSRCS_INT)] o_disp_rdy [RW];
    logic [`WDEF(`PRF_WBPORTS)] i_wb_en;
    iprIdx_t i_wb_idx [`PRF_WBPORTS];
    word_t i_wb_data [`PRF_WBPORTS];
    iprIdx_t i_read_idx [`PRF_READPORTS];
    word_t o_read_data [`PRF_READPORTS];
    logic [`WDEF(`PRF_READPORTS)] o_data_rdy;
    logic i_commit_vld;
    iprIdx_t i_commit_iprIdx;

    // reference model of map, free list, ready bits and data
    iprIdx_t model_map [`ARCH_REGS];
    iprIdx_t model_fl [$];
    logic model_rdy [`PRF_SIZE];
    word_t model_data [`PRF_SIZE];

    // expected dispatch contents of the last accepted group
    iprIdx_t exp_iprd [RW];
    iprIdx_t exp_old [RW];
    iprIdx_t exp_iprs [RW][NS];

    int errors;
    int timeouts;
    logic [31:0] rng;

    int_rename_prf u_int_rename_prf (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_iprIdx(input string name, input iprIdx_t exp, input iprIdx_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_rdy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_rename_ready(input string name, output bit ok);
        int n;
        n = 0;
        while (!o_rename_ready && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        ok = o_rename_ready;
        if (!ok) begin
            timeouts++;
            $display("%s: o_rename_ready stayed low for %0d cycles", name, WAIT_LIMIT);
        end
    endtask

    // drive one group, wait until it is accepted, update the model slot by slot
    task automatic rename_group(input string name, input ilrIdx_t rd0, input ilrIdx_t rd1,
                                input ilrIdx_t s00, input ilrIdx_t s01,
                                input ilrIdx_t s10, input ilrIdx_t s11, output bit ok);
        @(negedge clk);
        i_rename_rd[0] = rd0;
        i_rename_rd[1] = rd1;
        i_rename_rs[0][0] = s00;
        i_rename_rs[0][1] = s01;
        i_rename_rs[1][0] = s10;
        i_rename_rs[1][1] = s11;
        wait_rename_ready(name, ok);
        if (!ok) return;
        for (int s = 0; s < RW; s++) begin
            // sources see the destinations of earlier slots
            for (int k = 0; k < NS; k++) begin
                exp_iprs[s][k] = model_map[i_rename_rs[s][k]];
            end
            exp_old[s] = model_map[i_rename_rd[s]];
            exp_iprd[s] = '0;
            if (i_rename_rd[s] != '0) begin
                exp_iprd[s] = model_fl.pop_front();
                model_map[i_rename_rd[s]] = exp_iprd[s];
                model_rdy[exp_iprd[s]] = 1'b0;
            end
        end
        i_rename_vld = 1'b1;
        next_cycle();
        i_rename_vld = 1'b0;
    endtask

    task automatic check_dispatch(input string name, output bit ok);
        int n;
        n = 0;
        #1;
        while (!o_disp_vld && n < WAIT_LIMIT) begin
            next_cycle();
            #1;
            n++;
        end
        ok = o_disp_vld;
        if (!ok) begin
            timeouts++;
            $display("%s: o_disp_vld stayed low for %0d cycles", name, WAIT_LIMIT);
            return;
        end
        if (n != 0) begin
            errors++;
            $display("%s: dispatch arrived %0d cycles late", name, n);
        end
        for (int s = 0; s < RW; s++) begin
            check_iprIdx($sformatf("%s iprd[%0d]", name, s), exp_iprd[s], o_disp_iprd[s]);
            check_iprIdx($sformatf("%s old[%0d]", name, s), exp_old[s], o_disp_old_iprd[s]);
            for (int k = 0; k < NS; k++) begin
                check_iprIdx($sformatf("%s iprs[%0d][%0d]", name, s, k),
                             exp_iprs[s][k], o_disp_iprs[s][k]);
                check_rdy($sformatf("%s rdy[%0d][%0d]", name, s, k),
                          model_rdy[exp_iprs[s][k]], o_disp_rdy[s][k]);
            end
        end
    endtask

    task automatic test_reset_state();
        bit ok;
        check_rdy("reset disp_vld", 1'b0, o_disp_vld);
        wait_rename_ready("reset", ok);
        if (!ok) return;
        for (int base = 0; base < `ARCH_REGS; base += `PRF_READPORTS) begin
            for (int r = 0; r < `PRF_READPORTS; r++) begin
                i_read_idx[r] = iprIdx_t'(base + r);
            end
            #1;
            for (int r = 0; r < `PRF_READPORTS; r++) begin
                check_rdy($sformatf("reset rdy p%0d", base + r), 1'b1, o_data_rdy[r]);
            end
            if (base == 0) begin
                check_word("reset p0 data", '0, o_read_data[0]);
            end
            @(negedge clk);
        end
    endtask

    task automatic test_write_read();
        iprIdx_t idx [`PRF_WBPORTS];
        for (int t = 0; t < 4; t++) begin
            // two distinct registers in 1..47
            idx[0] = iprIdx_t'(1 + next_rand() % (`PRF_SIZE - 1));
            idx[1] = iprIdx_t'(idx[0] % (`PRF_SIZE - 1) + 1);
            for (int p = 0; p < `PRF_WBPORTS; p++) begin
                i_wb_en[p] = 1'b1;
                i_wb_idx[p] = idx[p];
                i_wb_data[p] = next_rand();
                i_read_idx[p] = idx[p];
                model_data[idx[p]] = i_wb_data[p];
                model_rdy[idx[p]] = 1'b1;
            end
            #1;
            for (int p = 0; p < `PRF_WBPORTS; p++) begin
                check_rdy($sformatf("write_read rdy p%0d", idx[p]), 1'b1, o_data_rdy[p]);
            end
            @(negedge clk);
            i_wb_en = '0;
            #1;
            for (int p = 0; p < `PRF_WBPORTS; p++) begin
                check_word($sformatf("write_read data p%0d", idx[p]),
                           model_data[idx[p]], o_read_data[p]);
            end
            @(negedge clk);
        end
    endtask

    task automatic test_rename_alloc();
        bit ok;
        ilrIdx_t a;
        ilrIdx_t b;
        // shared destination and forwarded sources
        rename_group("rename_alloc g0", 5, 5, 5, 0, 5, 5, ok);
        if (ok) check_dispatch("rename_alloc g0", ok);
        if (!ok) return;
        // architectural register 0 allocates nothing
        rename_group("rename_alloc g1", 0, ilrIdx_t'(next_rand()), ilrIdx_t'(next_rand()),
                     ilrIdx_t'(next_rand()), 0, ilrIdx_t'(next_rand()), ok);
        if (ok) check_dispatch("rename_alloc g1", ok);
        if (!ok) return;
        for (int g = 2; g < 6; g++) begin
            a = ilrIdx_t'(1 + next_rand() % 31);
            b = ilrIdx_t'(1 + next_rand() % 31);
            rename_group($sformatf("rename_alloc g%0d", g), a, b, ilrIdx_t'(next_rand()),
                         ilrIdx_t'(next_rand()), (g % 2 == 0) ? a : ilrIdx_t'(next_rand()),
                         ilrIdx_t'(next_rand()), ok);
            if (ok) check_dispatch($sformatf("rename_alloc g%0d", g), ok);
            if (!ok) return;
        end
    endtask

    task automatic test_wb_bypass();
        bit ok;
        ilrIdx_t a;
        a = ilrIdx_t'(1 + next_rand() % 31);
        rename_group("wb_bypass", a, 0, 0, 0, a, a, ok);
        if (!ok) return;
        // slot 1 waits on slot 0's new register, written while in dispatch
        i_wb_en = 2'b01;
        i_wb_idx[0] = exp_iprd[0];
        i_wb_data[0] = next_rand();
        i_read_idx[0] = exp_iprd[0];
        model_rdy[exp_iprd[0]] = 1'b1;
        model_data[exp_iprd[0]] = i_wb_data[0];
        check_dispatch("wb_bypass", ok);
        check_rdy("wb_bypass read rdy", model_rdy[exp_iprd[0]], o_data_rdy[0]);
        @(negedge clk);
        i_wb_en = '0;
        #1;
        check_word("wb_bypass read data", model_data[exp_iprd[0]], o_read_data[0]);
    endtask

    task automatic test_exhaust_commit();
        bit ok;
        iprIdx_t freed [$];
        while (model_fl.size() >= RW) begin
            rename_group("exhaust", ilrIdx_t'(1 + next_rand() % 31),
                         ilrIdx_t'(1 + next_rand() % 31), ilrIdx_t'(next_rand()),
                         ilrIdx_t'(next_rand()), ilrIdx_t'(next_rand()),
                         ilrIdx_t'(next_rand()), ok);
            if (ok) check_dispatch("exhaust", ok);
            if (!ok) return;
            freed.push_back(exp_old[0]);
            freed.push_back(exp_old[1]);
        end
        @(negedge clk);
        check_rdy("exhaust rename_ready", 1'b0, o_rename_ready);
        // return the oldest replaced registers one per cycle
        for (int j = 0; j < RW; j++) begin
            i_commit_vld = 1'b1;
            i_commit_iprIdx = freed[j];
            model_fl.push_back(freed[j]);
            @(negedge clk);
        end
        i_commit_vld = 1'b0;
        rename_group("commit_realloc", 3, 4, 1, 2, 3, 4, ok);
        if (ok) check_dispatch("commit_realloc", ok);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_rename_vld = 1'b0;
        for (int s = 0; s < RW; s++) begin
            i_rename_rd[s] = '0;
            for (int k = 0; k < NS; k++) begin
                i_rename_rs[s][k] = '0;
            end
        end
        i_wb_en = '0;
        for (int p = 0; p < `PRF_WBPORTS; p++) begin
            i_wb_idx[p] = '0;
            i_wb_data[p] = '0;
        end
        for (int r = 0; r < `PRF_READPORTS; r++) begin
            i_read_idx[r] = '0;
        end
        i_commit_vld = 1'b0;
        i_commit_iprIdx = '0;
        errors = 0;
        timeouts = 0;
        rng = 32'hb009;

        // identity map, free list 32..47, everything ready
        for (int a = 0; a < `ARCH_REGS; a++) begin
            model_map[a] = iprIdx_t'(a);
        end
        for (int i = `ARCH_REGS; i < `PRF_SIZE; i++) begin
            model_fl.push_back(iprIdx_t'(i));
        end
        for (int i = 0; i < `PRF_SIZE; i++) begin
            model_rdy[i] = 1'b1;
            model_data[i] = '0;
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        if (timeouts == 0) test_write_read();
        if (timeouts == 0) test_rename_alloc();
        if (timeouts == 0) test_wb_bypass();
        if (timeouts == 0) test_exhaust_commit();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
src/core_pkg.sv
src/prf_status_if.sv
src/regfile.sv
src/free_list.sv
src/rename_map.sv
src/int_rename_prf.sv
verification/tb_int_rename_prf.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_int_rename_prf -o tb_int_rename_prf
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_int_rename_prf)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
